// ==== source/video_pkg.sv ====
package video_pkg;

	////////////////////////////////////////////////////////////
	// scan side types

	// wide enough for the whole 800 x 525 raster
	typedef logic [10:0] coord_t;

	// blue [7:6], green [5:3], red [2:0]
	typedef logic [7:0] color_t;

	// visible area
	localparam coord_t h_active = 11'd640;
	localparam coord_t v_active = 11'd480;

	////////////////////////////////////////////////////////////
	// palette

	localparam color_t color_black = 8'b0000_0000;
	localparam color_t color_white = 8'b1111_1111;
	localparam color_t color_red = 8'b0000_0111;
	localparam color_t color_green = 8'b0011_1000;
	localparam color_t color_ship = 8'b0111_1000;
	localparam color_t color_alien = 8'b1010_1010;
	localparam color_t color_laser = color_white;

	// single-row borders of the game screen
	localparam coord_t scoreboard_top = 11'd0;
	localparam coord_t scoreboard_bottom = 11'd40;
	localparam coord_t lives_top = 11'd460;
	localparam coord_t lives_bottom = 11'd479;

	// start screen band, both rows inclusive
	localparam coord_t title_top = 11'd200;
	localparam coord_t title_bottom = 11'd279;

endpackage

// ==== source/game_pkg.sv ====
package game_pkg;

	////////////////////////////////////////////////////////////
	// state encodings

	// black -> start -> game -> black
	typedef enum logic [1:0] {
		mode_black,
		mode_start,
		mode_game
	} mode_e;

	typedef enum logic {
		march_right,
		march_left
	} march_e;

	typedef enum logic {
		laser_idle,
		laser_flying
	} laser_e;

	////////////////////////////////////////////////////////////
	// sprite geometry, all in pixels

	// one alien box, pitch is box plus gap
	localparam video_pkg::coord_t alien_w = 11'd30;
	localparam video_pkg::coord_t alien_h = 11'd20;
	localparam video_pkg::coord_t alien_pitch_x = 11'd50;
	localparam video_pkg::coord_t alien_pitch_y = 11'd30;
	// top left of alien 0 at zero offset
	localparam video_pkg::coord_t grid_x0 = 11'd70;
	localparam video_pkg::coord_t grid_y0 = 11'd90;
	localparam video_pkg::coord_t march_step = 11'd10;
	localparam video_pkg::coord_t drop_step = 11'd10;

	// ship sits on a fixed row
	localparam video_pkg::coord_t ship_y = 11'd420;
	localparam video_pkg::coord_t ship_w = 11'd40;
	localparam video_pkg::coord_t ship_h = 11'd20;
	localparam video_pkg::coord_t ship_x0 = 11'd300;
	localparam video_pkg::coord_t ship_step = 11'd8;

	localparam video_pkg::coord_t laser_w = 11'd2;
	localparam video_pkg::coord_t laser_h = 11'd10;
	localparam video_pkg::coord_t laser_speed = 11'd16;
	// shot is dropped once its top would go above this row
	localparam video_pkg::coord_t laser_ceiling = 11'd40;

endpackage

// ==== source/display_mode_ctrl.sv ====
`timescale 1ns/1ps

module display_mode_ctrl (
	input logic clk,
	input logic rst,
	input logic button_display,
	output game_pkg::mode_e mode,
	output logic game_restart
);

	logic button_q;
	logic button_rise;
	game_pkg::mode_e next_mode;

	// low sample followed by high sample
	assign button_rise = button_display && !button_q;

	// wrap back to black after the game screen
	always_comb begin
		case (mode)
			game_pkg::mode_black: next_mode = game_pkg::mode_start;
			game_pkg::mode_start: next_mode = game_pkg::mode_game;
			default: next_mode = game_pkg::mode_black;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			button_q <= 1'b0;
			mode <= game_pkg::mode_black;
			game_restart <= 1'b0;
		end else begin
			button_q <= button_display;
			// restart pulse lines up with the new mode
			game_restart <= button_rise;
			if (button_rise) begin
				mode <= next_mode;
			end
		end
	end

endmodule

// ==== source/alien_march.sv ====
`timescale 1ns/1ps

module alien_march #(
	parameter int alien_cols = 11,
	parameter int alien_rows = 2
) (
	input logic clk,
	input logic rst,
	input logic move_tick,
	input logic game_restart,
	output video_pkg::coord_t off_x,
	output video_pkg::coord_t off_y
);

	// formation bounding box, dead aliens included
	localparam int span_w = (alien_cols - 1) * game_pkg::alien_pitch_x + game_pkg::alien_w;
	localparam int span_h = (alien_rows - 1) * game_pkg::alien_pitch_y + game_pkg::alien_h;

	game_pkg::march_e dir;
	int left_next;
	int right_next;
	int bottom_next;
	logic at_edge;
	logic can_drop;

	////////////////////////////////////////////////////////////
	// edge look-ahead

	// off_x goes negative on the way left, so read it signed
	always_comb begin
		left_next = int'(game_pkg::grid_x0) + int'($signed(off_x)) - int'(game_pkg::march_step);
		right_next = int'(game_pkg::grid_x0) + span_w + int'($signed(off_x))
			+ int'(game_pkg::march_step);
		// exclusive bottom edge after one more drop
		bottom_next = int'(game_pkg::grid_y0) + span_h + int'(off_y) + int'(game_pkg::drop_step);
		if (dir == game_pkg::march_right) begin
			at_edge = right_next > int'(video_pkg::h_active);
		end else begin
			at_edge = left_next < 0;
		end
		// formation stops sinking at the bottom of the screen
		can_drop = bottom_next <= int'(video_pkg::v_active);
	end

	////////////////////////////////////////////////////////////
	// march / drop state

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			dir <= game_pkg::march_right;
			off_x <= '0;
			off_y <= '0;
		end else if (game_restart) begin
			dir <= game_pkg::march_right;
			off_x <= '0;
			off_y <= '0;
		end else if (move_tick) begin
			if (at_edge) begin
				// step down instead of sideways, then turn round
				if (can_drop) begin
					off_y <= off_y + game_pkg::drop_step;
				end
				if (dir == game_pkg::march_right) begin
					dir <= game_pkg::march_left;
				end else begin
					dir <= game_pkg::march_right;
				end
			end else if (dir == game_pkg::march_right) begin
				off_x <= off_x + game_pkg::march_step;
			end else begin
				off_x <= off_x - game_pkg::march_step;
			end
		end
	end

endmodule

// ==== source/alien_grid.sv ====
`timescale 1ns/1ps

module alien_grid #(
	parameter int alien_cols = 11,
	parameter int alien_rows = 2
) (
	input logic clk,
	input logic rst,
	input logic move_tick,
	input logic game_restart,
	input logic laser_active,
	input video_pkg::coord_t off_x,
	input video_pkg::coord_t off_y,
	input video_pkg::coord_t laser_x,
	input video_pkg::coord_t laser_y,
	input video_pkg::coord_t x,
	input video_pkg::coord_t y,
	output logic is_alien,
	output logic laser_hit
);

	localparam int n_alien = alien_cols * alien_rows;

	// index is row * alien_cols + col
	logic [n_alien-1:0] alive;
	logic [n_alien-1:0] in_box;
	logic [n_alien-1:0] overlap;
	logic [n_alien-1:0] hit_onehot;
	video_pkg::coord_t ax [n_alien];
	video_pkg::coord_t ay [n_alien];

	////////////////////////////////////////////////////////////
	// per-alien box decode

	for (genvar r = 0; r < alien_rows; r++) begin : g_row
		for (genvar c = 0; c < alien_cols; c++) begin : g_col
			localparam int idx = r * alien_cols + c;

			// home position plus formation offset, wraps as two's complement
			assign ax[idx] = video_pkg::coord_t'(game_pkg::grid_x0 + c * game_pkg::alien_pitch_x)
				+ off_x;
			assign ay[idx] = video_pkg::coord_t'(game_pkg::grid_y0 + r * game_pkg::alien_pitch_y)
				+ off_y;

			// scan pixel inside a live alien
			assign in_box[idx] = alive[idx]
				&& x >= ax[idx] && x < ax[idx] + game_pkg::alien_w
				&& y >= ay[idx] && y < ay[idx] + game_pkg::alien_h;

			// laser box intersects alien box
			assign overlap[idx] = alive[idx]
				&& laser_x < ax[idx] + game_pkg::alien_w
				&& ax[idx] < laser_x + game_pkg::laser_w
				&& laser_y < ay[idx] + game_pkg::alien_h
				&& ay[idx] < laser_y + game_pkg::laser_h;
		end
	end

	assign is_alien = |in_box;

	// keep only the lowest set bit
	assign hit_onehot = overlap & ~(overlap - 1'b1);

	////////////////////////////////////////////////////////////
	// alive mask and hit pulse

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			alive <= '1;
			laser_hit <= 1'b0;
		end else if (game_restart) begin
			alive <= '1;
			laser_hit <= 1'b0;
		end else if (move_tick && laser_active && !laser_hit) begin
			// laser still flying during the hit pulse, so skip that tick
			alive <= alive & ~hit_onehot;
			laser_hit <= |overlap;
		end else begin
			laser_hit <= 1'b0;
		end
	end

endmodule

// ==== source/ship_ctrl.sv ====
`timescale 1ns/1ps

module ship_ctrl (
	input logic clk,
	input logic rst,
	input logic move_tick,
	input logic game_restart,
	input logic button_left,
	input logic button_right,
	input logic button_shoot,
	input logic laser_hit,
	input video_pkg::coord_t x,
	input video_pkg::coord_t y,
	output video_pkg::coord_t laser_x,
	output video_pkg::coord_t laser_y,
	output logic laser_active,
	output logic is_ship,
	output logic is_laser
);

	// rightmost ship position, box still fully on screen
	localparam video_pkg::coord_t ship_x_max = video_pkg::h_active - game_pkg::ship_w;
	// laser centred on the ship, comes out at 19
	localparam video_pkg::coord_t laser_x_off = game_pkg::ship_w / 2 - game_pkg::laser_w / 2;

	video_pkg::coord_t ship_x;
	game_pkg::laser_e laser_state;
	logic step_en;
	logic laser_start;
	logic laser_rise;
	logic laser_gone;

	// restart wins over the tick
	assign step_en = move_tick && !game_restart;
	assign laser_active = laser_state == game_pkg::laser_flying;
	// next position would sit above the ceiling
	assign laser_gone = int'(laser_y) - int'(game_pkg::laser_speed) < int'(game_pkg::laser_ceiling);
	assign laser_start = step_en && !laser_active && button_shoot;
	assign laser_rise = step_en && laser_active && !laser_hit && !laser_gone;

	////////////////////////////////////////////////////////////
	// ship position

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ship_x <= game_pkg::ship_x0;
		end else if (game_restart) begin
			ship_x <= game_pkg::ship_x0;
		end else if (move_tick) begin
			// left has priority, clamp at both sides
			if (button_left) begin
				if (ship_x < game_pkg::ship_step) begin
					ship_x <= '0;
				end else begin
					ship_x <= ship_x - game_pkg::ship_step;
				end
			end else if (button_right) begin
				if (ship_x > ship_x_max - game_pkg::ship_step) begin
					ship_x <= ship_x_max;
				end else begin
					ship_x <= ship_x + game_pkg::ship_step;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// laser FSM

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			laser_state <= game_pkg::laser_idle;
		end else if (game_restart || laser_hit) begin
			laser_state <= game_pkg::laser_idle;
		end else if (move_tick) begin
			case (laser_state)
				game_pkg::laser_idle: begin
					if (button_shoot) begin
						laser_state <= game_pkg::laser_flying;
					end
				end
				default: begin
					if (laser_gone) begin
						laser_state <= game_pkg::laser_idle;
					end
				end
			endcase
		end
	end

	// shot coordinates, only meaningful while flying
	always_ff @(posedge clk) begin
		if (laser_start) begin
			laser_x <= ship_x + laser_x_off;
			laser_y <= game_pkg::ship_y - game_pkg::laser_h;
		end else if (laser_rise) begin
			laser_y <= laser_y - game_pkg::laser_speed;
		end
	end

	////////////////////////////////////////////////////////////
	// pixel flags

	assign is_ship = x >= ship_x && x < ship_x + game_pkg::ship_w
		&& y >= game_pkg::ship_y && y < game_pkg::ship_y + game_pkg::ship_h;

	assign is_laser = laser_active
		&& x >= laser_x && x < laser_x + game_pkg::laser_w
		&& y >= laser_y && y < laser_y + game_pkg::laser_h;

endmodule

// ==== source/pixel_mux.sv ====
`timescale 1ns/1ps

module pixel_mux (
	input logic clk,
	input logic rst,
	input video_pkg::coord_t x,
	input video_pkg::coord_t y,
	input game_pkg::mode_e mode,
	input logic is_alien,
	input logic is_ship,
	input logic is_laser,
	output video_pkg::color_t rgb
);

	video_pkg::color_t pix_color;
	logic on_screen;
	logic in_title;
	logic on_score_row;
	logic on_lives_row;

	assign on_screen = x < video_pkg::h_active && y < video_pkg::v_active;
	assign in_title = y >= video_pkg::title_top && y <= video_pkg::title_bottom;
	// border rows are one pixel high
	assign on_score_row = y == video_pkg::scoreboard_top || y == video_pkg::scoreboard_bottom;
	assign on_lives_row = y == video_pkg::lives_top || y == video_pkg::lives_bottom;

	// highest priority first
	always_comb begin
		pix_color = video_pkg::color_black;
		if (on_screen) begin
			case (mode)
				game_pkg::mode_start: begin
					if (in_title) begin
						pix_color = video_pkg::color_white;
					end
				end
				game_pkg::mode_game: begin
					if (on_score_row) begin
						pix_color = video_pkg::color_red;
					end else if (on_lives_row) begin
						pix_color = video_pkg::color_green;
					end else if (is_laser) begin
						pix_color = video_pkg::color_laser;
					end else if (is_ship) begin
						pix_color = video_pkg::color_ship;
					end else if (is_alien) begin
						pix_color = video_pkg::color_alien;
					end
				end
				default: pix_color = video_pkg::color_black;
			endcase
		end
	end

	// one pixel of latency
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rgb <= video_pkg::color_black;
		end else begin
			rgb <= pix_color;
		end
	end

endmodule

// ==== source/invaders_top.sv ====
`timescale 1ns/1ps

module invaders_top #(
	parameter int alien_cols = 11,
	parameter int alien_rows = 2
) (
	input logic clk,
	input logic rst,
	input video_pkg::coord_t x,
	input video_pkg::coord_t y,
	input logic button_left,
	input logic button_right,
	input logic button_shoot,
	input logic button_display,
	input logic move_tick,
	output video_pkg::color_t rgb
);

	game_pkg::mode_e mode;
	logic game_restart;
	video_pkg::coord_t off_x;
	video_pkg::coord_t off_y;
	video_pkg::coord_t laser_x;
	video_pkg::coord_t laser_y;
	logic laser_active;
	logic laser_hit;
	logic is_alien;
	logic is_ship;
	logic is_laser;

	////////////////////////////////////////////////////////////
	// game state

	display_mode_ctrl mode_ctrl_inst (
		.clk(clk),
		.rst(rst),
		.button_display(button_display),
		.mode(mode),
		.game_restart(game_restart)
	);

	alien_march #(
		.alien_cols(alien_cols),
		.alien_rows(alien_rows)
	) alien_march_inst (
		.clk(clk),
		.rst(rst),
		.move_tick(move_tick),
		.game_restart(game_restart),
		.off_x(off_x),
		.off_y(off_y)
	);

	// laser coordinates loop through here, hit comes back to the ship
	alien_grid #(
		.alien_cols(alien_cols),
		.alien_rows(alien_rows)
	) alien_grid_inst (
		.clk(clk),
		.rst(rst),
		.move_tick(move_tick),
		.game_restart(game_restart),
		.laser_active(laser_active),
		.off_x(off_x),
		.off_y(off_y),
		.laser_x(laser_x),
		.laser_y(laser_y),
		.x(x),
		.y(y),
		.is_alien(is_alien),
		.laser_hit(laser_hit)
	);

	ship_ctrl ship_ctrl_inst (
		.clk(clk),
		.rst(rst),
		.move_tick(move_tick),
		.game_restart(game_restart),
		.button_left(button_left),
		.button_right(button_right),
		.button_shoot(button_shoot),
		.laser_hit(laser_hit),
		.x(x),
		.y(y),
		.laser_x(laser_x),
		.laser_y(laser_y),
		.laser_active(laser_active),
		.is_ship(is_ship),
		.is_laser(is_laser)
	);

	////////////////////////////////////////////////////////////
	// colour out

	pixel_mux pixel_mux_inst (
		.clk(clk),
		.rst(rst),
		.x(x),
		.y(y),
		.mode(mode),
		.is_alien(is_alien),
		.is_ship(is_ship),
		.is_laser(is_laser),
		.rgb(rgb)
	);

endmodule

// ==== testbench/invaders_tb.sv ====
`timescale 1ns/1ps

module invaders_tb;

	////////////////////////////////////////////////////////////
	// geometry as plain ints for signed arithmetic

	localparam int alien_cols = 11;
	localparam int alien_rows = 2;
	localparam int n_alien = alien_cols * alien_rows;
	localparam int h_active = video_pkg::h_active;
	localparam int v_active = video_pkg::v_active;
	localparam int title_top = video_pkg::title_top;
	localparam int title_bottom = video_pkg::title_bottom;
	localparam int grid_x0 = game_pkg::grid_x0;
	localparam int grid_y0 = game_pkg::grid_y0;
	localparam int pitch_x = game_pkg::alien_pitch_x;
	localparam int pitch_y = game_pkg::alien_pitch_y;
	localparam int alien_w = game_pkg::alien_w;
	localparam int alien_h = game_pkg::alien_h;
	localparam int march_step = game_pkg::march_step;
	localparam int drop_step = game_pkg::drop_step;
	localparam int ship_y = game_pkg::ship_y;
	localparam int ship_w = game_pkg::ship_w;
	localparam int ship_h = game_pkg::ship_h;
	localparam int ship_step = game_pkg::ship_step;
	localparam int ship_max = h_active - ship_w;
	localparam int laser_w = game_pkg::laser_w;
	localparam int laser_h = game_pkg::laser_h;
	localparam int laser_speed = game_pkg::laser_speed;
	localparam int laser_ceiling = game_pkg::laser_ceiling;
	// shot leaves the ship here
	localparam int laser_x_off = 19;

	logic clk;
	logic rst;
	video_pkg::coord_t x;
	video_pkg::coord_t y;
	logic button_left;
	logic button_right;
	logic button_shoot;
	logic button_display;
	logic move_tick;
	video_pkg::color_t rgb;

	// reference model state
	game_pkg::mode_e m_mode;
	int off_x;
	int off_y;
	bit dir_left;
	bit alive [n_alien];
	int ship_x;
	bit las_on;
	int las_x;
	int las_y;
	int hits;
	int misses;
	int drops;

	// pending probes with the cycle their colour shows up
	video_pkg::color_t exp_q [$];
	int due_q [$];
	int px_q [$];
	int py_q [$];
	int cycle_cnt = 0;
	string test_name = "reset";
	bit [31:0] lcg_state = 32'd27610;

	invaders_top #(
		.alien_cols(alien_cols),
		.alien_rows(alien_rows)
	) invaders_top_inst (
		.clk(clk),
		.rst(rst),
		.x(x),
		.y(y),
		.button_left(button_left),
		.button_right(button_right),
		.button_shoot(button_shoot),
		.button_display(button_display),
		.move_tick(move_tick),
		.rgb(rgb)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	////////////////////////////////////////////////////////////
	// failure reporting and compare

	task automatic report_failure(input string reason);
		$display("%s", reason);
		$display("Verification failed");
		$fatal(1, "run stopped at first failure");
	endtask

	task automatic check_value(input string name, input video_pkg::color_t expected,
			input video_pkg::color_t actual);
		if (actual !== expected) begin
			report_failure($sformatf("Error: %s expected %b actual %b", name, expected, actual));
		end
	endtask

	// rgb lags the probe by one cycle and is read mid-cycle
	always @(negedge clk) begin
		if (due_q.size() > 0) begin
			if (due_q[0] <= cycle_cnt) begin
				check_value($sformatf("%s pixel (%0d,%0d)", test_name, px_q[0], py_q[0]),
					exp_q[0], rgb);
				void'(exp_q.pop_front());
				void'(due_q.pop_front());
				void'(px_q.pop_front());
				void'(py_q.pop_front());
			end
		end
	end

	////////////////////////////////////////////////////////////
	// reference model

	function automatic int lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return int'(lcg_state >> 8);
	endfunction

	function automatic int alien_x(input int i);
		return grid_x0 + (i % alien_cols) * pitch_x + off_x;
	endfunction

	function automatic int alien_y(input int i);
		return grid_y0 + (i / alien_cols) * pitch_y + off_y;
	endfunction

	function automatic bit in_box(input int px, input int py, input int bx, input int by,
			input int w, input int h);
		return px >= bx && px < bx + w && py >= by && py < by + h;
	endfunction

	// expected colour of one pixel from the model state
	function automatic video_pkg::color_t expected_color(input int px, input int py);
		video_pkg::color_t c;
		int i;
		c = video_pkg::color_black;
		if (px < h_active && py < v_active) begin
			if (m_mode == game_pkg::mode_start) begin
				if (py >= title_top && py <= title_bottom) begin
					c = video_pkg::color_white;
				end
			end else if (m_mode == game_pkg::mode_game) begin
				if (py == 0 || py == 40) begin
					c = video_pkg::color_red;
				end else if (py == 460 || py == 479) begin
					c = video_pkg::color_green;
				end else if (las_on && in_box(px, py, las_x, las_y, laser_w, laser_h)) begin
					c = video_pkg::color_laser;
				end else if (in_box(px, py, ship_x, ship_y, ship_w, ship_h)) begin
					c = video_pkg::color_ship;
				end else begin
					for (i = 0; i < n_alien; i++) begin
						if (alive[i] && in_box(px, py, alien_x(i), alien_y(i), alien_w, alien_h)) begin
							c = video_pkg::color_alien;
						end
					end
				end
			end
		end
		return c;
	endfunction

	task automatic restart_model();
		off_x = 0;
		off_y = 0;
		dir_left = 1'b0;
		ship_x = game_pkg::ship_x0;
		las_on = 1'b0;
		for (int i = 0; i < n_alien; i++) begin
			alive[i] = 1'b1;
		end
	endtask

	// one game tick where collision sees the state from before the tick
	task automatic model_tick(input bit left, input bit right, input bit shoot);
		int hit_idx;
		int ax;
		int ay;
		hit_idx = -1;
		if (las_on) begin
			for (int i = n_alien - 1; i >= 0; i--) begin
				ax = alien_x(i);
				ay = alien_y(i);
				if (alive[i] && las_x < ax + alien_w && ax < las_x + laser_w
						&& las_y < ay + alien_h && ay < las_y + laser_h) begin
					hit_idx = i;
				end
			end
		end
		// laser
		if (!las_on) begin
			if (shoot) begin
				las_on = 1'b1;
				las_x = ship_x + laser_x_off;
				las_y = ship_y - laser_h;
			end
		end else if (hit_idx >= 0) begin
			alive[hit_idx] = 1'b0;
			las_on = 1'b0;
			hits++;
		end else if (las_y - laser_speed < laser_ceiling) begin
			las_on = 1'b0;
			misses++;
		end else begin
			las_y = las_y - laser_speed;
		end
		// ship move with left winning
		if (left) begin
			ship_x = (ship_x - ship_step < 0) ? 0 : ship_x - ship_step;
		end else if (right) begin
			ship_x = (ship_x + ship_step > ship_max) ? ship_max : ship_x + ship_step;
		end
		// formation box counts dead aliens too
		if ((!dir_left && alien_x(alien_cols - 1) + alien_w + march_step > h_active)
				|| (dir_left && alien_x(0) - march_step < 0)) begin
			drops++;
			if (alien_y(n_alien - 1) + alien_h + drop_step <= v_active) begin
				off_y = off_y + drop_step;
			end
			dir_left = !dir_left;
		end else begin
			off_x = dir_left ? off_x - march_step : off_x + march_step;
		end
	endtask

	////////////////////////////////////////////////////////////
	// stimulus

	task automatic drain_probes();
		int n;
		n = 0;
		while (due_q.size() > 0) begin
			@(negedge clk);
			n++;
			if (n > 20) begin
				report_failure("timeout: probed pixels never came back from the DUT");
			end
		end
	endtask

	task automatic start_test(input string name);
		drain_probes();
		test_name = name;
		$display("test %s", name);
	endtask

	task automatic probe(input int px, input int py);
		@(negedge clk);
		x = px[10:0];
		y = py[10:0];
		exp_q.push_back(expected_color(px, py));
		due_q.push_back(cycle_cnt + 1);
		px_q.push_back(px);
		py_q.push_back(py);
	endtask

	task automatic probe_random(input int n);
		repeat (n) begin
			probe(lcg_next() % 700, lcg_next() % 520);
		end
	endtask

	task automatic probe_title();
		int rx;
		repeat (3) begin
			rx = lcg_next() % h_active;
			probe(rx, title_top - 1);
			probe(rx, title_top);
			probe(rx, 240);
			probe(rx, title_bottom);
			probe(rx, title_bottom + 1);
		end
	endtask

	task automatic probe_borders();
		int rx;
		repeat (3) begin
			rx = lcg_next() % h_active;
			probe(rx, 0);
			probe(rx, 1);
			probe(rx, 39);
			probe(rx, 40);
			probe(rx, 41);
			probe(rx, 459);
			probe(rx, 460);
			probe(rx, 478);
			probe(rx, 479);
		end
	endtask

	// corners, centre and both sides of every alien slot
	task automatic probe_aliens();
		int ax;
		int ay;
		for (int i = 0; i < n_alien; i++) begin
			ax = alien_x(i);
			ay = alien_y(i);
			probe(ax, ay);
			probe(ax + alien_w - 1, ay + alien_h - 1);
			probe(ax + 15, ay + 10);
			probe(ax + alien_w, ay + 5);
			if (ax > 0) begin
				probe(ax - 1, ay + 5);
			end
		end
	endtask

	task automatic probe_ship();
		probe(ship_x, ship_y);
		probe(ship_x + ship_w - 1, ship_y + ship_h - 1);
		probe(ship_x + ship_w, ship_y + 10);
		probe(ship_x + 20, ship_y - 1);
		if (ship_x > 0) begin
			probe(ship_x - 1, ship_y + 10);
		end
	endtask

	task automatic game_tick(input bit left, input bit right, input bit shoot);
		drain_probes();
		@(negedge clk);
		button_left = left;
		button_right = right;
		button_shoot = shoot;
		move_tick = 1'b1;
		model_tick(left, right, shoot);
		@(negedge clk);
		move_tick = 1'b0;
		button_left = 1'b0;
		button_right = 1'b0;
		button_shoot = 1'b0;
		// hit pulse and laser clear settle here
		repeat (2) @(negedge clk);
	endtask

	task automatic press_display();
		drain_probes();
		@(negedge clk);
		button_display = 1'b1;
		@(negedge clk);
		button_display = 1'b0;
		repeat (3) @(negedge clk);
		case (m_mode)
			game_pkg::mode_black: m_mode = game_pkg::mode_start;
			game_pkg::mode_start: m_mode = game_pkg::mode_game;
			default: m_mode = game_pkg::mode_black;
		endcase
		restart_model();
	endtask

	// steer, fire, then follow the shot until it is gone
	task automatic fire_shot(input int target);
		int n;
		int last_x;
		int last_y;
		if (target < 0) begin
			target = 0;
		end
		if (target > ship_max) begin
			target = ship_max;
		end
		n = 0;
		while (ship_x > target + 7 || ship_x < target - 7) begin
			game_tick(ship_x > target, ship_x < target, 1'b0);
			n++;
			if (n > 100) begin
				report_failure("timeout: ship never reached its firing position");
			end
		end
		game_tick(1'b0, 1'b0, 1'b1);
		n = 0;
		last_x = las_x;
		last_y = las_y;
		while (las_on) begin
			last_x = las_x;
			last_y = las_y;
			probe(las_x, las_y);
			probe(las_x + 1, las_y + laser_h - 1);
			probe(las_x + laser_w, las_y);
			probe(las_x, las_y - 1);
			// scoreboard row above the laser column
			probe(las_x, 40);
			game_tick(1'b0, 1'b0, 1'b0);
			n++;
			if (n > 40) begin
				report_failure("timeout: laser shot never ended");
			end
		end
		// ended shot leaves no laser at its last place or one step higher
		probe(last_x, last_y);
		probe(last_x + 1, last_y - laser_speed);
		probe_aliens();
	endtask

	initial begin
		int k;
		int rounds;
		int shots;
		int target;
		int idx;
		int tries;
		rst = 1'b1;
		x = '0;
		y = '0;
		button_left = 1'b0;
		button_right = 1'b0;
		button_shoot = 1'b0;
		button_display = 1'b0;
		move_tick = 1'b0;
		m_mode = game_pkg::mode_black;
		restart_model();
		hits = 0;
		misses = 0;
		drops = 0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		start_test("reset_black");
		probe_random(40);
		press_display();
		start_test("start_screen");
		probe_title();
		probe_random(40);

		press_display();
		start_test("game_entry");
		probe_borders();
		probe_aliens();
		probe_ship();
		probe_random(60);

		// three drops means both edges were hit
		start_test("march");
		rounds = 0;
		while (rounds < 8 || drops < 3) begin
			k = lcg_next() % 8 + 1;
			repeat (k) game_tick(1'b0, 1'b0, 1'b0);
			probe_aliens();
			probe_random(10);
			rounds++;
			if (rounds > 40) begin
				report_failure("timeout: formation never reached both edges");
			end
		end

		start_test("ship");
		repeat (40) game_tick(1'b1, 1'b0, 1'b0);
		probe_ship();
		repeat (80) game_tick(1'b0, 1'b1, 1'b0);
		probe_ship();
		repeat (20) begin
			k = lcg_next();
			repeat (k % 6 + 1) game_tick(k[4], k[5], 1'b0);
			probe_ship();
		end

		// alternate aimed shots and shots from the screen sides
		start_test("shot");
		shots = 0;
		while (hits == 0 || misses == 0) begin
			if (shots % 2 == 0) begin
				idx = lcg_next() % n_alien;
				tries = 0;
				while (!alive[idx] && tries < n_alien) begin
					idx = (idx + 1) % n_alien;
					tries++;
				end
				target = alien_x(idx) + alien_w / 2 - laser_x_off;
			end else if (shots % 4 == 1) begin
				target = 0;
			end else begin
				target = ship_max;
			end
			fire_shot(target);
			shots++;
			if (shots > 12) begin
				report_failure("timeout: shots never produced both a hit and a miss");
			end
		end

		start_test("restart");
		press_display();
		probe_random(30);
		press_display();
		probe_title();
		press_display();
		probe_aliens();
		probe_ship();
		probe_borders();
		drain_probes();

		$display("Verification passed");
		$finish;
	end

endmodule

// ==== filelist.f ====
source/video_pkg.sv
source/game_pkg.sv
source/display_mode_ctrl.sv
source/alien_march.sv
source/alien_grid.sv
source/ship_ctrl.sv
source/pixel_mux.sv
source/invaders_top.sv
testbench/invaders_tb.sv
